// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // Integer ALU operations on rs1 and either rs2 or the immediate
  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    sll    = 4'd2,
    slt    = 4'd3,
    sltu   = 4'd4,
    xor_op = 4'd5,
    srl    = 4'd6,
    sra    = 4'd7,
    or_op  = 4'd8,
    and_op = 4'd9
  } alu_op_t;

  typedef enum logic [2:0] {
    lb  = 3'd0,
    lh  = 3'd1,
    lw  = 3'd2,
    lbu = 3'd3,
    lhu = 3'd4,
    sb  = 3'd5,
    sh  = 3'd6,
    sw  = 3'd7
  } lsu_op_t;

  // Same order as funct3, so bit 2 marks the divide group
  typedef enum logic [2:0] {
    mul    = 3'd0,
    mulh   = 3'd1,
    mulhsu = 3'd2,
    mulhu  = 3'd3,
    div    = 3'd4,
    divu   = 3'd5,
    rem    = 3'd6,
    remu   = 3'd7
  } muldiv_op_t;

endpackage

`default_nettype wire

// ==== hdl/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

  localparam int ECAUSE_W = 4;

  // Machine mode cause codes as numbered in mcause
  typedef enum logic [ECAUSE_W-1:0] {
    illegal_instruction = ECAUSE_W'(2),
    breakpoint          = ECAUSE_W'(3),
    env_call_mach       = ECAUSE_W'(11)
  } ecause_t;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] rdata1,
  input  logic [XLEN-1:0] rdata2,
  input  logic [XLEN-1:0] imm,
  input  logic            sel,
  input  isa_pkg::alu_op_t alu_op,
  output logic [XLEN-1:0] res
);
  import isa_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] op_b;
  logic [SHW-1:0]  shamt;

  assign op_b  = sel ? rdata2 : imm;  // Register form when rs2 is read
  assign shamt = op_b[SHW-1:0];

  always_comb begin
    case (alu_op)
      add:     res = rdata1 + op_b;
      sub:     res = rdata1 - op_b;
      sll:     res = rdata1 << shamt;
      slt:     res = XLEN'($signed(rdata1) < $signed(op_b));
      sltu:    res = XLEN'(rdata1 < op_b);
      xor_op:  res = rdata1 ^ op_b;
      srl:     res = rdata1 >> shamt;
      sra:     res = $signed(rdata1) >>> shamt;
      or_op:   res = rdata1 | op_b;
      and_op:  res = rdata1 & op_b;
      default: res = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/muldiv.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv #(
  parameter int XLEN = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  input  logic [XLEN-1:0]       rdata1,
  input  logic [XLEN-1:0]       rdata2,
  input  isa_pkg::muldiv_op_t   md_op,
  output logic                  ready,
  output logic [XLEN-1:0]       result
);
  import isa_pkg::*;

  localparam int CW = $clog2(XLEN);

  muldiv_op_t        op_r;
  logic              busy;
  logic [CW-1:0]     count;
  logic              last;
  logic              a_signed, b_signed, a_neg, b_neg;
  logic [XLEN-1:0]   a_mag, b_mag;
  logic [XLEN-1:0]   d_r;          // Multiplicand or divisor magnitude
  logic [2*XLEN:0]   p, p_next;    // Upper part accumulates, lower part holds multiplier or quotient
  logic              neg_r, rneg_r, dz_r;
  logic [XLEN:0]     mul_sum, rem_sh;
  logic [XLEN+1:0]   diff;
  logic [2*XLEN-1:0] prod;
  logic [XLEN-1:0]   quo_s, rem_s;

  always_comb begin
    a_signed = 1'b0;
    b_signed = 1'b0;
    case (md_op)
      mulh, div, rem: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      mulhsu:  a_signed = 1'b1;
      default: ;
    endcase
    a_neg = a_signed & rdata1[XLEN-1];
    b_neg = b_signed & rdata2[XLEN-1];
    a_mag = a_neg ? -rdata1 : rdata1;
    b_mag = b_neg ? -rdata2 : rdata2;
  end

  assign last = (count == CW'(XLEN - 1));

  always_comb begin
    mul_sum = p[2*XLEN:XLEN] + (p[0] ? {1'b0, d_r} : '0);
    rem_sh  = {p[2*XLEN-1:XLEN], p[XLEN-1]};
    diff    = {1'b0, rem_sh} - {2'b00, d_r};
    if (op_r[2]) begin
      // Restore when the trial subtraction goes negative
      p_next = {1'b0, (diff[XLEN+1] ? rem_sh[XLEN-1:0] : diff[XLEN-1:0]),
                p[XLEN-2:0], ~diff[XLEN+1]};
    end else begin
      p_next = {mul_sum, p[XLEN-1:0]} >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy  <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else begin
      ready <= busy & last;
      if (busy) begin
        count <= count + 1'b1;
        busy  <= !last;
      end else if (enable) begin
        busy  <= 1'b1;
        count <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && enable) begin
      op_r   <= md_op;
      d_r    <= b_mag;
      p      <= {(XLEN+1)'(0), a_mag};
      neg_r  <= a_neg ^ b_neg;
      rneg_r <= a_neg;  // Remainder takes the sign of the dividend
      dz_r   <= (rdata2 == '0);
    end else if (busy) begin
      p <= p_next;
    end
  end

  always_comb begin
    prod  = neg_r ? -p[2*XLEN-1:0] : p[2*XLEN-1:0];
    quo_s = neg_r ? -p[XLEN-1:0] : p[XLEN-1:0];
    rem_s = rneg_r ? -p[2*XLEN-1:XLEN] : p[2*XLEN-1:XLEN];
    case (op_r)
      mul:                 result = prod[XLEN-1:0];
      mulh, mulhsu, mulhu: result = prod[2*XLEN-1:XLEN];
      div, divu:           result = dz_r ? '1 : quo_s;
      default:             result = rem_s;
    endcase
  end

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst) ready |=> !ready);

  // A request arriving mid operation must not restart the sequence
  a_busy_ignores_enable: assert property (@(posedge clk) disable iff (!rst)
    (busy && enable && !last) |=> (busy && count == $past(count) + 1'b1));

endmodule

`default_nettype wire

// ==== hdl/lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu #(
  parameter int XLEN = 32
) (
  input  isa_pkg::lsu_op_t  lsu_op,
  input  logic [1:0]        offset,
  input  logic [XLEN-1:0]   sdata,
  input  logic [XLEN-1:0]   mem_rdata,
  output logic [XLEN/8-1:0] wstrb,
  output logic [XLEN-1:0]   wdata_aligned,
  output logic [XLEN-1:0]   ldata
);
  import isa_pkg::*;

  localparam int NB = XLEN / 8;

  logic [XLEN-1:0] lane;

  assign lane = mem_rdata >> {offset, 3'b000};  // Addressed byte moves down to bit 0

  always_comb begin
    wstrb         = '0;
    wdata_aligned = sdata;
    ldata         = '0;
    case (lsu_op)
      lb:  ldata = XLEN'($signed(lane[7:0]));
      lh:  ldata = XLEN'($signed(lane[15:0]));
      lw:  ldata = XLEN'($signed(lane[31:0]));
      lbu: ldata = XLEN'(lane[7:0]);
      lhu: ldata = XLEN'(lane[15:0]);
      sb: begin
        wstrb         = NB'(1) << offset;
        wdata_aligned = {NB{sdata[7:0]}};
      end
      sh: begin
        wstrb         = NB'(3) << {offset[1], 1'b0};
        wdata_aligned = {(XLEN/16){sdata[15:0]}};
      end
      sw: begin
        wstrb         = NB'(4'hf);
        wdata_aligned = {(XLEN/32){sdata[31:0]}};
      end
      default: ;
    endcase
  end

  always_comb begin
    assert (wstrb == '0 || lsu_op inside {sb, sh, sw}) else $error("lsu: byte strobes on a load");
  end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
  parameter int XLEN = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [XLEN-1:0]     pc,
  input  logic [31:0]         instr,
  input  logic [XLEN-1:0]     rdata1,
  input  logic [XLEN-1:0]     rdata2,
  input  logic [XLEN-1:0]     imm,
  input  logic [4:0]          waddr,
  input  logic                rden1, rden2, wren_in, legal,
  input  logic                lui, auipc, jal, jalr, load, store, muldiv, ecall, ebreak,
  input  isa_pkg::alu_op_t    alu_op,
  input  isa_pkg::lsu_op_t    lsu_op,
  input  isa_pkg::muldiv_op_t md_op,
  input  logic                clear,
  output logic [XLEN-1:0]     alu_a, alu_b, alu_imm,
  output logic                alu_sel,
  output isa_pkg::alu_op_t    alu_op_out,
  input  logic [XLEN-1:0]     alu_res,
  output isa_pkg::lsu_op_t    lsu_op_out,
  output logic [1:0]          lsu_offset,
  output logic [XLEN-1:0]     lsu_sdata,
  input  logic [XLEN-1:0]     lsu_ldata,
  input  logic [XLEN/8-1:0]   lsu_wstrb,
  input  logic [XLEN-1:0]     lsu_wdata,
  output logic                md_enable,
  output isa_pkg::muldiv_op_t md_op_out,
  input  logic                md_ready,
  input  logic [XLEN-1:0]     md_result,
  output logic                mem_valid,
  output logic [XLEN-1:0]     mem_addr, mem_wdata,
  output logic [XLEN/8-1:0]   mem_wstrb,
  input  logic                mem_ready,
  output logic                wren,
  output logic [4:0]          wd_addr,
  output logic [XLEN-1:0]     wdata,
  output logic                exception,
  output trap_pkg::ecause_t   ecause,
  output logic [XLEN-1:0]     etval,
  output logic                stall
);
  import isa_pkg::*;
  import trap_pkg::*;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] imm;
    logic [4:0]      waddr;
    logic            rden1, rden2, wren_in, legal;
    logic            lui, auipc, jal, jalr, load, store, muldiv, ecall, ebreak;
    alu_op_t         alu_op;
    lsu_op_t         lsu_op;
    muldiv_op_t      md_op;
  } ex_instr_t;

  ex_instr_t       fresh, held, cur;
  logic            stall_q;  // Previous cycle stalled so the held copy is replayed
  logic            trap, mem_op, md_wait, mem_wait, we;
  logic [XLEN-1:0] npc;

  assign fresh = {pc, instr, rdata1, rdata2, imm, waddr, rden1, rden2, wren_in, legal,
                  lui, auipc, jal, jalr, load, store, muldiv, ecall, ebreak,
                  alu_op, lsu_op, md_op};
  assign cur   = stall_q ? held : fresh;

  assign alu_a      = cur.rden1 ? cur.rdata1 : '0;
  assign alu_b      = cur.rden2 ? cur.rdata2 : '0;
  assign alu_imm    = cur.imm;
  assign alu_sel    = cur.rden2 & ~(cur.load | cur.store);  // Addresses are always rs1 + imm
  assign alu_op_out = cur.alu_op;

  assign npc = cur.pc + ((cur.instr[1:0] == 2'b11) ? XLEN'(4) : XLEN'(2));

  always_comb begin
    trap   = 1'b1;
    ecause = illegal_instruction;
    if (!cur.legal) begin
      ecause = illegal_instruction;
    end else if (cur.ebreak) begin
      ecause = breakpoint;
    end else if (cur.ecall) begin
      ecause = env_call_mach;
    end else begin
      trap = 1'b0;
    end
  end

  assign exception = trap & ~clear;
  assign etval     = trap ? XLEN'(cur.instr) : '0;

  // A trapping instruction never reaches memory or the multiplier
  assign mem_op     = (cur.load | cur.store) & ~trap;
  assign mem_valid  = mem_op & ~clear;
  assign mem_addr   = alu_res;
  assign mem_wdata  = lsu_wdata;
  assign mem_wstrb  = lsu_wstrb;
  assign lsu_op_out = cur.lsu_op;
  assign lsu_offset = alu_res[1:0];
  assign lsu_sdata  = alu_b;

  assign md_enable = cur.muldiv & ~trap & ~stall_q & ~clear;  // Issue cycle only
  assign md_op_out = cur.md_op;

  assign md_wait  = cur.muldiv & ~trap & ~md_ready;
  assign mem_wait = mem_op & ~mem_ready;
  assign stall    = (md_wait | mem_wait) & ~clear;

  always_comb begin
    if (cur.auipc) begin
      wdata = cur.pc + cur.imm;
    end else if (cur.lui) begin
      wdata = cur.imm;
    end else if (cur.jal || cur.jalr) begin
      wdata = npc;
    end else if (cur.load) begin
      wdata = lsu_ldata;
    end else if (cur.muldiv) begin
      wdata = md_result;
    end else begin
      wdata = alu_res;
    end
  end

  always_comb begin
    we = cur.wren_in;
    if (cur.load || cur.muldiv) begin
      we = |cur.waddr;
    end
    if (cur.store) begin
      we = 1'b0;
    end
  end

  assign wren    = we & ~stall & ~clear & ~trap;
  assign wd_addr = cur.waddr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= stall;
    end
  end

  always_ff @(posedge clk) begin
    held <= cur;
  end

  a_wren_no_trap: assert property (@(posedge clk) disable iff (!rst) !(wren && exception));

  a_mem_kind: assert property (@(posedge clk) disable iff (!rst)
    mem_valid |-> (cur.load || cur.store));

  // The replayed access keeps its address until memory answers or clear drops it
  a_mem_hold: assert property (@(posedge clk) disable iff (!rst)
    (mem_valid && !mem_ready) |=> (clear || (mem_valid && $stable(mem_addr))));

endmodule

`default_nettype wire

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
  parameter int XLEN = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [XLEN-1:0]     pc,
  input  logic [31:0]         instr,
  input  logic [XLEN-1:0]     rdata1,
  input  logic [XLEN-1:0]     rdata2,
  input  logic [XLEN-1:0]     imm,
  input  logic [4:0]          waddr,
  input  logic                rden1, rden2, wren_in, legal,
  input  logic                lui, auipc, jal, jalr, load, store, muldiv, ecall, ebreak,
  input  isa_pkg::alu_op_t    alu_op,
  input  isa_pkg::lsu_op_t    lsu_op,
  input  isa_pkg::muldiv_op_t md_op,
  input  logic                clear,
  output logic                wren,
  output logic [4:0]          wd_addr,
  output logic [XLEN-1:0]     wdata,
  output logic                exception,
  output trap_pkg::ecause_t   ecause,
  output logic [XLEN-1:0]     etval,
  output logic                stall,
  output logic                mem_valid,
  output logic [XLEN-1:0]     mem_addr,
  output logic [XLEN-1:0]     mem_wdata,
  output logic [XLEN/8-1:0]   mem_wstrb,
  input  logic [XLEN-1:0]     mem_rdata,
  input  logic                mem_ready
);
  import isa_pkg::*;

  logic [XLEN-1:0]   alu_a, alu_b, alu_imm, alu_res;
  logic              alu_sel;
  alu_op_t           alu_op_out;
  lsu_op_t           lsu_op_out;
  logic [1:0]        lsu_offset;
  logic [XLEN-1:0]   lsu_sdata, lsu_ldata, lsu_wdata;
  logic [XLEN/8-1:0] lsu_wstrb;
  logic              md_enable, md_ready;
  muldiv_op_t        md_op_out;
  logic [XLEN-1:0]   md_result;

  execute_stage #(.XLEN(XLEN)) execute_stage_inst (.*);

  alu #(.XLEN(XLEN)) alu_inst (
    .rdata1 (alu_a),
    .rdata2 (alu_b),
    .imm    (alu_imm),
    .sel    (alu_sel),
    .alu_op (alu_op_out),
    .res    (alu_res)
  );

  // The multiplier shares the zeroed operands prepared for the ALU
  muldiv #(.XLEN(XLEN)) muldiv_inst (
    .clk    (clk),
    .rst    (rst),
    .enable (md_enable),
    .rdata1 (alu_a),
    .rdata2 (alu_b),
    .md_op  (md_op_out),
    .ready  (md_ready),
    .result (md_result)
  );

  lsu #(.XLEN(XLEN)) lsu_inst (
    .lsu_op        (lsu_op_out),
    .offset        (lsu_offset),
    .sdata         (lsu_sdata),
    .mem_rdata     (mem_rdata),
    .wstrb         (lsu_wstrb),
    .wdata_aligned (lsu_wdata),
    .ldata         (lsu_ldata)
  );

endmodule

`default_nettype wire

// ==== test/execute_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit_tb;
  import isa_pkg::*;
  import trap_pkg::*;

  localparam int XLEN    = 32;
  localparam int N_ALU   = 40;
  localparam int N_UPPER = 8;
  localparam int N_MD    = 24;
  localparam int N_MEM   = 40;
  localparam int N_TRAP  = 6;
  localparam int N_INSTR = N_ALU + N_UPPER + N_MD + N_MEM + N_TRAP + 2;
  // Worst case is one divide per instruction plus idle cycles between tests
  localparam longint TIMEOUT_NS = longint'(N_INSTR + 20) * (XLEN + 8) * 100;

  // Bit 2 legal, bit 1 ebreak, bit 0 ecall
  localparam logic [2:0] TRAP_MIX [N_TRAP] = '{3'b000, 3'b011, 3'b001, 3'b110, 3'b111, 3'b101};

  logic clk, rst;
  logic [XLEN-1:0] pc, rdata1, rdata2, imm;
  logic [31:0] instr;
  logic [4:0] waddr;
  logic rden1, rden2, wren_in, legal;
  logic lui, auipc, jal, jalr, load, store, muldiv, ecall, ebreak, clear;
  alu_op_t alu_op;
  lsu_op_t lsu_op;
  muldiv_op_t md_op;
  logic wren, exception, stall, mem_valid, mem_ready;
  logic [4:0] wd_addr;
  logic [XLEN-1:0] wdata, etval, mem_addr, mem_wdata, mem_rdata;
  logic [XLEN/8-1:0] mem_wstrb;
  ecause_t ecause;

  logic active;  // An instruction is presented
  logic first;   // Its issue cycle
  logic [31:0] rng = 32'd7;
  int errors = 0;
  int instr_count = 0;
  int tests_run = 0;
  int base_errors = 0;
  int base_instr = 0;

  logic [XLEN-1:0] op_a, op_b, exp_wdata, exp_addr, exp_sdata;
  logic [3:0] exp_strb;
  logic exp_wren, exp_exc, mem_kind, md_kind;
  ecause_t exp_cause;

  execute_unit #(.XLEN(XLEN)) execute_unit_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the DUT did not finish the instruction sequence in time");
    $display("Errors found");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a, b);
    case (op)
      add:     return a + b;
      sub:     return a - b;
      sll:     return a << b[4:0];
      slt:     return {31'b0, $signed(a) < $signed(b)};
      sltu:    return {31'b0, a < b};
      xor_op:  return a ^ b;
      srl:     return a >> b[4:0];
      sra:     return 32'($signed(a) >>> b[4:0]);
      or_op:   return a | b;
      and_op:  return a & b;
      default: return 32'b0;
    endcase
  endfunction

  function automatic logic [31:0] muldiv_ref(input muldiv_op_t op, input logic [31:0] a, b);
    logic [63:0] sa, sb, ua, ub, prod;
    logic ovf;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      mul: return a * b;
      mulh: begin
        prod = sa * sb;
        return prod[63:32];
      end
      mulhsu: begin
        prod = sa * ub;
        return prod[63:32];
      end
      mulhu: begin
        prod = ua * ub;
        return prod[63:32];
      end
      div:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : 32'($signed(a) / $signed(b)));
      divu: return (b == 0) ? 32'hffff_ffff : a / b;
      rem:  return (b == 0) ? a : (ovf ? 32'b0 : 32'($signed(a) % $signed(b)));
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input lsu_op_t op, input logic [1:0] off,
                                           input logic [31:0] rd);
    logic [31:0] lane;
    lane = rd >> (8 * off);
    case (op)
      lb:      return {{24{lane[7]}}, lane[7:0]};
      lh:      return {{16{lane[15]}}, lane[15:0]};
      lbu:     return {24'b0, lane[7:0]};
      lhu:     return {16'b0, lane[15:0]};
      default: return rd;
    endcase
  endfunction

  function automatic logic [3:0] strobe_ref(input lsu_op_t op, input logic [1:0] off);
    case (op)
      sb:      return 4'b0001 << off;
      sh:      return 4'b0011 << off;
      sw:      return 4'b1111;
      default: return 4'b0000;
    endcase
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

  always_comb begin
    op_a      = rden1 ? rdata1 : '0;
    op_b      = rden2 ? rdata2 : '0;
    exp_exc   = !legal || ebreak || ecall;
    exp_cause = !legal ? illegal_instruction : (ebreak ? breakpoint : env_call_mach);
    mem_kind  = (load || store) && !exp_exc;
    md_kind   = muldiv && !exp_exc;
    exp_addr  = op_a + imm;
    exp_strb  = strobe_ref(lsu_op, exp_addr[1:0]);
    exp_sdata = op_b << (8 * exp_addr[1:0]);
    if (auipc) begin
      exp_wdata = pc + imm;
    end else if (lui) begin
      exp_wdata = imm;
    end else if (jal || jalr) begin
      exp_wdata = pc + ((instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
    end else if (load) begin
      exp_wdata = load_ref(lsu_op, exp_addr[1:0], mem_rdata);
    end else if (muldiv) begin
      exp_wdata = muldiv_ref(md_op, op_a, op_b);
    end else begin
      exp_wdata = alu_ref(alu_op, op_a, rden2 ? rdata2 : imm);
    end
    if (exp_exc || store) begin
      exp_wren = 1'b0;
    end else if (load || muldiv) begin
      exp_wren = (waddr != 5'd0);
    end else begin
      exp_wren = wren_in;
    end
  end

  task automatic report_mismatch(input string what);
    errors++;
    $display("ERR %0t ns: %s", $time, what);
  endtask

  // Outputs settle long before the falling edge
  a_idle: assert property (@(negedge clk) disable iff (!rst)
    !active |-> (!stall && !wren && !exception && !mem_valid))
    else report_mismatch("idle stage shows activity");
  a_no_stall: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && !mem_kind && !md_kind) |-> !stall)
    else report_mismatch("stall on a single cycle instruction");
  a_md_issue: assert property (@(negedge clk) disable iff (!rst)
    (active && first && !clear && md_kind) |-> stall)
    else report_mismatch("no stall in the multiply/divide issue cycle");
  a_mem_wait: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && mem_kind) |-> (mem_valid && stall == !mem_ready))
    else report_mismatch($sformatf("mem_valid %b stall %b with mem_ready %b",
                                   mem_valid, stall, mem_ready));
  a_wren: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && !stall) |-> (wren == exp_wren))
    else report_mismatch($sformatf("wren %b, expected %b", wren, exp_wren));
  a_wdata: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && !stall && !exp_exc && !store) |->
      (wdata == exp_wdata && wd_addr == waddr))
    else report_mismatch($sformatf("wdata %h to x%0d, expected %h to x%0d",
                                   wdata, wd_addr, exp_wdata, waddr));
  a_trap: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear) |-> (exception == exp_exc))
    else report_mismatch($sformatf("exception %b, expected %b", exception, exp_exc));
  a_cause: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && exp_exc) |-> (ecause == exp_cause && etval == instr))
    else report_mismatch($sformatf("cause %0d etval %h, expected %0d and %h",
                                   ecause, etval, exp_cause, instr));
  a_addr: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && mem_kind) |-> (mem_addr == exp_addr && mem_wstrb == exp_strb))
    else report_mismatch($sformatf("mem_addr %h strobes %b, expected %h and %b",
                                   mem_addr, mem_wstrb, exp_addr, exp_strb));
  a_sdata: assert property (@(negedge clk) disable iff (!rst)
    (active && !clear && mem_kind && store) |->
      ((mem_wdata & byte_mask(exp_strb)) == (exp_sdata & byte_mask(exp_strb))))
    else report_mismatch($sformatf("mem_wdata %h, expected lanes of %h", mem_wdata, exp_sdata));
  a_clear: assert property (@(negedge clk) disable iff (!rst)
    clear |-> (!stall && !wren && !exception && !mem_valid))
    else report_mismatch("clear left the instruction alive");

  task automatic drive_nop();
    pc      <= '0;
    instr   <= 32'h0000_0013;
    rdata1  <= '0;
    rdata2  <= '0;
    imm     <= '0;
    waddr   <= 5'd0;
    {rden1, rden2, wren_in} <= 3'b000;
    legal   <= 1'b1;
    {lui, auipc, jal, jalr} <= 4'b0000;
    {load, store, muldiv, ecall, ebreak} <= 5'b00000;
    alu_op  <= add;
    lsu_op  <= lw;
    md_op   <= mul;
    clear   <= 1'b0;
  endtask

  // Called right after the fields are driven; the memory model answers after delay cycles
  task automatic complete(input int delay);
    int waited;
    waited = 0;
    active    <= 1'b1;
    first     <= 1'b1;
    mem_rdata <= next_random();  // Held until the next instruction so the reference can read it
    mem_ready <= (delay == 0);
    @(negedge clk);
    while (stall) begin
      @(posedge clk);
      waited++;
      first     <= 1'b0;
      mem_ready <= (waited >= delay);
      @(negedge clk);
    end
    instr_count++;
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    drive_nop();
    active    <= 1'b0;
    first     <= 1'b0;
    mem_ready <= 1'b0;
    @(posedge clk);
    tests_run++;
    $display("%-8s %0d instructions, %0d errors", name, instr_count - base_instr,
             errors - base_errors);
    base_instr  = instr_count;
    base_errors = errors;
  endtask

  task automatic alu_ops();
    for (int i = 0; i < N_ALU; i++) begin
      @(posedge clk);
      drive_nop();
      pc      <= next_random();
      instr   <= next_random() | 32'h3;
      rdata1  <= next_random();
      rdata2  <= next_random();
      imm     <= next_random();
      waddr   <= 5'(next_random());
      rden1   <= (next_random() % 4) != 0;
      rden2   <= 1'(next_random());
      wren_in <= 1'(next_random());
      alu_op  <= alu_op_t'(4'(next_random() % 10));
      complete(0);
    end
  endtask

  task automatic upper_ops();
    for (int i = 0; i < N_UPPER; i++) begin
      @(posedge clk);
      drive_nop();
      pc      <= next_random() & 32'hffff_fffe;
      imm     <= next_random();
      waddr   <= 5'd1 + 5'(next_random() % 31);
      wren_in <= 1'b1;
      if (i % 2 == 0) begin
        instr <= next_random() | 32'h3;
      end else begin
        instr <= (next_random() & 32'hffff_fffc) | (next_random() % 3);  // Compressed
      end
      case (i / 2)
        0:       lui <= 1'b1;
        1:       auipc <= 1'b1;
        2:       jal <= 1'b1;
        default: jalr <= 1'b1;
      endcase
      complete(0);
    end
  endtask

  task automatic muldiv_ops();
    logic [31:0] a, b;
    for (int i = 0; i < N_MD; i++) begin
      a = next_random();
      b = next_random();
      if (i % 3 == 1) begin
        b = '0;
      end else if (i % 3 == 2) begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      @(posedge clk);
      drive_nop();
      {muldiv, rden1, rden2} <= 3'b111;
      rdata1  <= a;
      rdata2  <= b;
      md_op   <= muldiv_op_t'(3'(i / 3));
      waddr   <= 5'(next_random());
      wren_in <= 1'(next_random());
      complete(0);
    end
  endtask

  task automatic memory_ops();
    lsu_op_t op;
    logic is_st;
    int step;
    for (int rep = 0; rep < 2; rep++) begin
      for (int k = 0; k < 8; k++) begin
        op    = lsu_op_t'(3'(k));
        is_st = op inside {sb, sh, sw};
        step  = (op inside {lb, lbu, sb}) ? 1 : ((op inside {lh, lhu, sh}) ? 2 : 4);
        for (int off = 0; off < 4; off += step) begin
          @(posedge clk);
          drive_nop();
          load    <= !is_st;
          store   <= is_st;
          lsu_op  <= op;
          rden1   <= 1'b1;
          rden2   <= is_st;
          rdata1  <= next_random() & 32'hffff_fffc;
          rdata2  <= next_random();
          imm     <= (next_random() & 32'h0000_07fc) | 32'(off);
          waddr   <= 5'(next_random());
          wren_in <= 1'b1;  // A store must still not write
          complete(int'(next_random() % 4));
        end
      end
    end
  endtask

  task automatic trap_ops();
    for (int i = 0; i < N_TRAP; i++) begin
      @(posedge clk);
      drive_nop();
      instr   <= next_random();
      rden1   <= 1'b1;
      rdata1  <= next_random();
      waddr   <= 5'd7;
      wren_in <= 1'b1;
      legal   <= TRAP_MIX[i][2];
      ebreak  <= TRAP_MIX[i][1];
      ecall   <= TRAP_MIX[i][0];
      complete(0);
    end
  endtask

  task automatic clear_divide();
    @(posedge clk);
    drive_nop();
    {muldiv, rden1, rden2, wren_in} <= 4'b1111;
    md_op  <= div;
    rdata1 <= next_random();
    rdata2 <= next_random() | 32'h1;
    waddr  <= 5'd9;
    active <= 1'b1;
    first  <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      first <= 1'b0;
    end
    clear <= 1'b1;
    @(posedge clk);
    instr_count++;
    drive_nop();
    {rden1, rden2, wren_in} <= 3'b111;
    alu_op <= xor_op;
    rdata1 <= next_random();
    rdata2 <= next_random();
    waddr  <= 5'd10;
    complete(0);
  endtask

  initial begin
    rst = 1'b0;
    drive_nop();
    mem_rdata <= '0;
    mem_ready <= 1'b0;
    active    <= 1'b0;
    first     <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    alu_ops();
    finish_test("alu");
    upper_ops();
    finish_test("upper");
    muldiv_ops();
    finish_test("muldiv");
    memory_ops();
    finish_test("memory");
    trap_ops();
    finish_test("traps");
    clear_divide();
    finish_test("clear");
    $display("%0d tests, %0d instructions, %0d errors", tests_run, instr_count, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_unit.f ====
hdl/isa_pkg.sv
hdl/trap_pkg.sv
hdl/alu.sv
hdl/muldiv.sv
hdl/lsu.sv
hdl/execute_stage.sv
hdl/execute_unit.sv
test/execute_unit_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module execute_unit_tb -f exec_unit.f
	./obj_dir/Vexecute_unit_tb | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
